/* include/global_buffer_settings.svh */
// global buffer sizing macros
// tile count, bank depth, data, address and tag widths

`ifndef GLOBAL_BUFFER_SETTINGS_SVH
`define GLOBAL_BUFFER_SETTINGS_SVH

// tiles in the chain
`define GLB_NUM_TILES 4

// words held by each tile bank
`define GLB_BANK_WORDS 64

// host word and address split
`define GLB_DATA_WIDTH 32
`define GLB_TILE_ID_WIDTH 2
`define GLB_WORD_ADDR_WIDTH 6

// read tag, top bit marks last of batch
`define GLB_TAG_WIDTH 8

`endif

/* hdl/global_buffer_pkg.sv */
// global buffer shared types
// command enum, host request, chain packet, payload union, read response

`include "global_buffer_settings.svh"

package global_buffer_pkg;

    // one bit request command
    typedef enum logic [0:0] {
        proc_write = 1'b0,
        proc_read  = 1'b1
    } proc_cmd_e;

    // request as presented by the host
    typedef struct packed {
        logic                              valid;
        proc_cmd_e                         cmd;
        logic [`GLB_TILE_ID_WIDTH-1:0]     tile_id;
        logic [`GLB_WORD_ADDR_WIDTH-1:0]   word_addr;
        logic [`GLB_DATA_WIDTH-1:0]        data;
        logic [`GLB_TAG_WIDTH-1:0]         tag;
    } host_req_t;

    // write view of the payload word
    typedef struct packed {
        logic [`GLB_DATA_WIDTH-1:0] data;
    } wr_body_t;

    // read request view, tag in the top bits
    typedef struct packed {
        logic [`GLB_TAG_WIDTH-1:0]                  tag;
        logic [`GLB_DATA_WIDTH-`GLB_TAG_WIDTH-1:0]  pad;
    } rdrq_body_t;

    // payload decoded by cmd
    typedef union packed {
        wr_body_t   wr;
        rdrq_body_t rdrq;
    } payload_u;

    // west to east processor packet
    typedef struct packed {
        logic                              valid;
        proc_cmd_e                         cmd;
        logic [`GLB_TILE_ID_WIDTH-1:0]     tile_id;
        logic [`GLB_WORD_ADDR_WIDTH-1:0]   word_addr;
        payload_u                          payload;
    } packet_t;

    // read response on the response chain
    typedef struct packed {
        logic                          valid;
        logic [`GLB_TAG_WIDTH-1:0]     tag;
        logic [`GLB_DATA_WIDTH-1:0]    data;
    } rdrs_packet_t;

endpackage

/* hdl/glb_proc_ingress.sv */
// west edge ingress of the global buffer chain
// stall register and chain clock enable
// host request to packet register, payload union fill

module glb_proc_ingress (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  global_buffer_pkg::host_req_t  host_req,
    output global_buffer_pkg::packet_t    packet,
    output logic                          clk_en
);

    logic                        stall_d1;
    logic                        load;
    logic                        pkt_valid_q;
    global_buffer_pkg::packet_t  pkt_next;
    global_buffer_pkg::packet_t  pkt_q;

    // stall registered once for the whole chain
    // held high in reset so clk_en starts low
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stall_d1 <= 1'b1;
        end else begin
            stall_d1 <= stall;
        end
    end

    assign clk_en = ~stall_d1;

    // build the west edge packet
    always_comb begin
        pkt_next = '0;
        pkt_next.valid = host_req.valid;
        pkt_next.cmd = host_req.cmd;
        pkt_next.tile_id = host_req.tile_id;
        pkt_next.word_addr = host_req.word_addr;
        // write carries the data word, read carries the tag
        if (host_req.cmd == global_buffer_pkg::proc_write) begin
            pkt_next.payload.wr.data = host_req.data;
        end else begin
            pkt_next.payload.rdrq.tag = host_req.tag;
        end
    end

    // hold while frozen
    // a request right after stall release still loads, the held slot is empty then
    assign load = clk_en || host_req.valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pkt_valid_q <= 1'b0;
        end else if (load) begin
            pkt_valid_q <= pkt_next.valid;
        end
    end

    // packet fields, no reset needed
    always_ff @(posedge clk) begin
        if (load) begin
            pkt_q <= pkt_next;
        end
    end

    always_comb begin
        packet = pkt_q;
        packet.valid = pkt_valid_q;
    end

    // host keeps requests off while stall is up
    a_no_req_in_stall: assert property (
        @(posedge clk) disable iff (reset)
        host_req.valid |-> !stall
    ) else $error("ingress: request presented while stall is high");

endmodule

/* hdl/glb_tile.sv */
// one global buffer tile
// bank with synchronous read, packet pass-through stage
// response chain merge of the local read result

`include "global_buffer_settings.svh"

module glb_tile #(
    parameter int unsigned tile_index = 0
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             clk_en,
    input  global_buffer_pkg::packet_t       packet_w,
    input  global_buffer_pkg::rdrs_packet_t  rdrs_w,
    output global_buffer_pkg::packet_t       packet_e,
    output global_buffer_pkg::rdrs_packet_t  rdrs_e
);

    // id this tile answers to
    localparam logic [`GLB_TILE_ID_WIDTH-1:0] tile_id =
        tile_index[`GLB_TILE_ID_WIDTH-1:0];

    logic [`GLB_DATA_WIDTH-1:0]        bank [`GLB_BANK_WORDS];

    logic                              hit;
    logic                              wr_hit;
    logic                              rd_hit;

    // pass-through stage
    logic                              pkt_valid_q;
    global_buffer_pkg::packet_t        pkt_q;

    // local read result
    logic                              rd_valid_q;
    logic [`GLB_TAG_WIDTH-1:0]         rd_tag_q;
    logic [`GLB_DATA_WIDTH-1:0]        rd_data_q;

    // forwarded response from the west
    logic                              rdrs_valid_q;
    global_buffer_pkg::rdrs_packet_t   rdrs_q;

    // address decode, only while the chain advances
    always_comb begin
        hit = clk_en && packet_w.valid && (packet_w.tile_id == tile_id);
        wr_hit = hit && (packet_w.cmd == global_buffer_pkg::proc_write);
        rd_hit = hit && (packet_w.cmd == global_buffer_pkg::proc_read);
    end

    // control bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pkt_valid_q <= 1'b0;
            rd_valid_q <= 1'b0;
            rdrs_valid_q <= 1'b0;
        end else if (clk_en) begin
            pkt_valid_q <= packet_w.valid;
            rd_valid_q <= rd_hit;
            rdrs_valid_q <= rdrs_w.valid;
        end
    end

    // payload registers and bank
    always_ff @(posedge clk) begin
        if (clk_en) begin
            pkt_q <= packet_w;
            rdrs_q <= rdrs_w;
            // tag from the read view of the union
            rd_tag_q <= packet_w.payload.rdrq.tag;
        end
        if (wr_hit) begin
            bank[packet_w.word_addr] <= packet_w.payload.wr.data;
        end
        // synchronous read lines up with the pass-through stage
        if (rd_hit) begin
            rd_data_q <= bank[packet_w.word_addr];
        end
    end

    // east packet, every packet goes on
    always_comb begin
        packet_e = pkt_q;
        packet_e.valid = pkt_valid_q;
    end

    // own read result takes the slot
    // otherwise the west response moves on
    always_comb begin
        if (rd_valid_q) begin
            rdrs_e.valid = 1'b1;
            rdrs_e.tag = rd_tag_q;
            rdrs_e.data = rd_data_q;
        end else begin
            rdrs_e = rdrs_q;
            rdrs_e.valid = rdrs_valid_q;
        end
    end

    // a request owns one slot along the chain
    // so a western response in the same slot means a duplicate tile id
    a_no_collision: assert property (
        @(posedge clk) disable iff (reset)
        rd_hit |-> !rdrs_w.valid
    ) else $error("tile %0d: local read collides with western response", tile_index);

endmodule

/* hdl/glb_rdrs_egress.sv */
// east edge egress of the response chain
// final response register, host read port and interrupt pulse

`include "global_buffer_settings.svh"

module glb_rdrs_egress (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             clk_en,
    input  global_buffer_pkg::rdrs_packet_t  rdrs_in,
    output global_buffer_pkg::rdrs_packet_t  rdrs,
    output logic                             interrupt_pulse
);

    logic                              rdrs_valid_q;
    logic                              pulse_q;
    global_buffer_pkg::rdrs_packet_t   rdrs_q;

    // valid bit and batch end flag
    // top tag bit marks the batch end
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrs_valid_q <= 1'b0;
            pulse_q <= 1'b0;
        end else if (clk_en) begin
            rdrs_valid_q <= rdrs_in.valid;
            pulse_q <= rdrs_in.valid && rdrs_in.tag[`GLB_TAG_WIDTH-1];
        end
    end

    // tag and data
    always_ff @(posedge clk) begin
        if (clk_en) begin
            rdrs_q <= rdrs_in;
        end
    end

    // held response stays hidden while frozen
    // it shows once when the chain resumes
    always_comb begin
        rdrs = rdrs_q;
        rdrs.valid = rdrs_valid_q && clk_en;
    end

    // gated like the response valid
    assign interrupt_pulse = pulse_q && clk_en;

    // pulse only together with a response
    a_pulse_with_rdrs: assert property (
        @(posedge clk) disable iff (reset)
        interrupt_pulse |-> rdrs.valid
    ) else $error("egress: interrupt pulse without read response");

endmodule

/* hdl/global_buffer.sv */
// global buffer top level
// ingress, chain of tiles, response egress

`include "global_buffer_settings.svh"

module global_buffer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stall,
    input  global_buffer_pkg::host_req_t     host_req,
    output global_buffer_pkg::rdrs_packet_t  rdrs,
    output logic                             interrupt_pulse
);

    // chain wiring, element k feeds tile k
    // last packet element is the open east edge
    global_buffer_pkg::packet_t       packet_chain [`GLB_NUM_TILES+1];
    global_buffer_pkg::rdrs_packet_t  rdrs_chain [`GLB_NUM_TILES+1];

    logic                             clk_en;

    // nothing enters the response chain from the west
    assign rdrs_chain[0] = '0;

    glb_proc_ingress u_ingress (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .host_req (host_req),
        .packet   (packet_chain[0]),
        .clk_en   (clk_en)
    );

    // one register stage per tile, both chains
    for (genvar k = 0; k < `GLB_NUM_TILES; k++) begin : g_tile
        glb_tile #(
            .tile_index (k)
        ) u_tile (
            .clk      (clk),
            .reset    (reset),
            .clk_en   (clk_en),
            .packet_w (packet_chain[k]),
            .rdrs_w   (rdrs_chain[k]),
            .packet_e (packet_chain[k+1]),
            .rdrs_e   (rdrs_chain[k+1])
        );
    end

    glb_rdrs_egress u_egress (
        .clk             (clk),
        .reset           (reset),
        .clk_en          (clk_en),
        .rdrs_in         (rdrs_chain[`GLB_NUM_TILES]),
        .rdrs            (rdrs),
        .interrupt_pulse (interrupt_pulse)
    );

endmodule

/* tb/tb_global_buffer.sv */
// global buffer testbench
// bank model, reference function, compare tasks, cycle timeout
// directed, random, interrupt, stall and mid-run reset phases

`include "global_buffer_settings.svh"

module tb_global_buffer;

    localparam int num_tiles = `GLB_NUM_TILES;
    localparam int latency = `GLB_NUM_TILES + 2;
    localparam int model_words = 1 << (`GLB_TILE_ID_WIDTH + `GLB_WORD_ADDR_WIDTH);
    localparam int tag_top = `GLB_TAG_WIDTH - 1;

    // phase lengths, also feed the timeout
    localparam int reset_cycles = 16;
    localparam int settle_cycles = 4;
    localparam int random_ops = 200;
    localparam int interrupt_ops = 24;
    localparam int stall_ops = 160;
    localparam int reset_reads = 16;
    localparam int run_cycles = 2 * reset_cycles + 2 * settle_cycles
        + 2 * num_tiles * (latency + 4) + random_ops + num_tiles + interrupt_ops
        + stall_ops + (stall_ops / 10) * 6 + 3 + reset_reads + 6 * (latency + 2);
    localparam int cycle_limit = 2 * run_cycles + latency;

    // one outstanding read
    typedef struct packed {
        global_buffer_pkg::rdrs_packet_t rsp;
        logic                            check_data;
        logic                            timed;
        int                              drive_cycle;
    } expect_t;

    logic                             clk;
    logic                             reset;
    logic                             stall;
    global_buffer_pkg::host_req_t     host_req;
    global_buffer_pkg::rdrs_packet_t  rdrs;
    logic                             interrupt_pulse;

    // mirror of every bank, indexed {tile_id, word_addr}
    logic [`GLB_DATA_WIDTH-1:0]       model [model_words];
    bit                               written [model_words];
    expect_t                          expect_q [$];
    logic [`GLB_TAG_WIDTH-2:0]        tag_seq;
    logic                             stall_seen = 1'b0;
    int                               cycle = 0;

    global_buffer dut (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .host_req        (host_req),
        .rdrs            (rdrs),
        .interrupt_pulse (interrupt_pulse)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        stop_run($sformatf("error at time %0t: %s", $time, msg));
    endtask

    // expected response for a read, from the model
    function automatic global_buffer_pkg::rdrs_packet_t expected_rdrs(
        input logic [`GLB_TILE_ID_WIDTH-1:0]   tile_id,
        input logic [`GLB_WORD_ADDR_WIDTH-1:0] word_addr,
        input logic [`GLB_TAG_WIDTH-1:0]       tag
    );
        global_buffer_pkg::rdrs_packet_t rsp;
        rsp.valid = 1'b1;
        rsp.tag = tag;
        rsp.data = model[{tile_id, word_addr}];
        return rsp;
    endfunction

    task automatic check_rdrs(
        input global_buffer_pkg::rdrs_packet_t got,
        input global_buffer_pkg::rdrs_packet_t want,
        input logic                            check_data
    );
        if (got.tag !== want.tag) begin
            value_error($sformatf("read tag %h, expected %h", got.tag, want.tag));
        end
        if (check_data && (got.data !== want.data)) begin
            value_error($sformatf("read data %h for tag %h, expected %h",
                got.data, got.tag, want.data));
        end
    endtask

    task automatic check_interrupt(input logic got, input logic want);
        if (want && (got !== 1'b1)) begin
            stop_run("interrupt pulse missing for a read marked last of batch");
        end
        if (!want && (got !== 1'b0)) begin
            stop_run("interrupt pulse raised for a read not marked last of batch");
        end
    endtask

    task automatic check_delay(input int got, input int want);
        if (got != want) begin
            value_error($sformatf("read answered after %0d cycles, expected %0d", got, want));
        end
    endtask

    // cycle count and hang guard
    always @(posedge clk) begin
        cycle <= cycle + 1;
        stall_seen <= stall;
        if (cycle >= cycle_limit) begin
            stop_run($sformatf("timeout: run went past %0d cycles", cycle_limit));
        end
    end

    // compare process, mid-cycle where outputs are settled
    always @(negedge clk) begin
        expect_t entry;
        if (reset) begin
            if (rdrs.valid || interrupt_pulse) begin
                stop_run("read response or interrupt seen during reset");
            end
        end else begin
            if (interrupt_pulse && !rdrs.valid) begin
                stop_run("interrupt pulse without a read response");
            end
            if (rdrs.valid) begin
                if (stall_seen) begin
                    stop_run("read response seen while the chain is stalled");
                end
                if (expect_q.size() == 0) begin
                    stop_run("read response with no outstanding read");
                end
                entry = expect_q.pop_front();
                check_rdrs(rdrs, entry.rsp, entry.check_data);
                check_interrupt(interrupt_pulse, entry.rsp.tag[tag_top]);
                if (entry.timed) begin
                    check_delay(cycle - entry.drive_cycle, latency);
                end
            end
        end
    end

    // inputs change 1 unit after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        host_req = '0;
        stall = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic issue_write(
        input logic [`GLB_TILE_ID_WIDTH-1:0]   tile_id,
        input logic [`GLB_WORD_ADDR_WIDTH-1:0] word_addr,
        input logic [`GLB_DATA_WIDTH-1:0]      data
    );
        host_req = '0;
        host_req.valid = 1'b1;
        host_req.cmd = global_buffer_pkg::proc_write;
        host_req.tile_id = tile_id;
        host_req.word_addr = word_addr;
        host_req.data = data;
        model[{tile_id, word_addr}] = data;
        written[{tile_id, word_addr}] = 1'b1;
        next_cycle();
        host_req = '0;
    endtask

    // tag is the last flag over a running sequence number
    task automatic issue_read(
        input logic [`GLB_TILE_ID_WIDTH-1:0]   tile_id,
        input logic [`GLB_WORD_ADDR_WIDTH-1:0] word_addr,
        input logic                            last,
        input logic                            timed
    );
        expect_t                   entry;
        logic [`GLB_TAG_WIDTH-1:0] tag;
        tag = {last, tag_seq};
        tag_seq = tag_seq + 1'b1;
        entry.rsp = expected_rdrs(tile_id, word_addr, tag);
        entry.check_data = written[{tile_id, word_addr}];
        entry.timed = timed;
        entry.drive_cycle = cycle;
        expect_q.push_back(entry);
        host_req = '0;
        host_req.valid = 1'b1;
        host_req.cmd = global_buffer_pkg::proc_read;
        host_req.tile_id = tile_id;
        host_req.word_addr = word_addr;
        host_req.tag = tag;
        next_cycle();
        host_req = '0;
    endtask

    task automatic wait_drain();
        host_req = '0;
        while (expect_q.size() != 0) next_cycle();
        next_cycle();
    endtask

    // no request while stall is high
    // the next request lands in the release cycle, chain still frozen
    task automatic stall_window(input int len);
        host_req = '0;
        stall = 1'b1;
        repeat (len) next_cycle();
        stall = 1'b0;
    endtask

    // low word addresses so reads often hit written words
    task automatic random_op(input logic timed, input logic last_ok);
        int unsigned                  r;
        logic [`GLB_DATA_WIDTH-1:0]   data;
        r = $urandom();
        data = `GLB_DATA_WIDTH'($urandom());
        if (r[16]) begin
            issue_write(`GLB_TILE_ID_WIDTH'(r % num_tiles),
                `GLB_WORD_ADDR_WIDTH'((r >> 8) % 8), data);
        end else begin
            issue_read(`GLB_TILE_ID_WIDTH'(r % num_tiles),
                `GLB_WORD_ADDR_WIDTH'((r >> 8) % 8), last_ok && r[20], timed);
        end
    endtask

    task automatic run_directed();
        logic [`GLB_DATA_WIDTH-1:0] data;
        for (int t = 0; t < num_tiles; t++) begin
            data = `GLB_DATA_WIDTH'($urandom());
            issue_write(`GLB_TILE_ID_WIDTH'(t), `GLB_WORD_ADDR_WIDTH'(5 + t), data);
            issue_read(`GLB_TILE_ID_WIDTH'(t), `GLB_WORD_ADDR_WIDTH'(5 + t), 1'b0, 1'b1);
            wait_drain();
            // top word, upper address bits
            data = `GLB_DATA_WIDTH'($urandom());
            issue_write(`GLB_TILE_ID_WIDTH'(t), `GLB_WORD_ADDR_WIDTH'(`GLB_BANK_WORDS - 1), data);
            issue_read(`GLB_TILE_ID_WIDTH'(t), `GLB_WORD_ADDR_WIDTH'(`GLB_BANK_WORDS - 1),
                1'b0, 1'b1);
            wait_drain();
        end
    endtask

    task automatic run_interrupts();
        logic last;
        for (int t = 0; t < num_tiles; t++) begin
            issue_write(`GLB_TILE_ID_WIDTH'(t), `GLB_WORD_ADDR_WIDTH'(9),
                `GLB_DATA_WIDTH'($urandom()));
        end
        for (int i = 0; i < interrupt_ops; i++) begin
            // both flag values forced early, rest random
            last = (i % 4 == 0) ? 1'b1 : (i % 4 == 1) ? 1'b0 : 1'($urandom_range(0, 1));
            issue_read(`GLB_TILE_ID_WIDTH'(i % num_tiles), `GLB_WORD_ADDR_WIDTH'(9), last, 1'b1);
        end
        wait_drain();
    endtask

    task automatic run_stalls();
        int unsigned len;
        for (int i = 0; i < stall_ops; i++) begin
            if (i % 10 == 5) begin
                len = $urandom_range(1, 6);
                stall_window(int'(len));
            end else begin
                random_op(1'b0, 1'b1);
            end
        end
        wait_drain();
    endtask

    // reads in flight at reset must never come out
    task automatic run_reset_midway();
        for (int t = 0; t < 3; t++) begin
            issue_read(`GLB_TILE_ID_WIDTH'(t), `GLB_WORD_ADDR_WIDTH'(7), 1'b1, 1'b0);
        end
        reset = 1'b1;
        expect_q.delete();
        for (int i = 0; i < model_words; i++) written[i] = 1'b0;
        repeat (reset_cycles) next_cycle();
        reset = 1'b0;
        idle_cycles(settle_cycles);
        // unwritten words in the new run, data unchecked
        for (int i = 0; i < reset_reads; i++) begin
            issue_read(`GLB_TILE_ID_WIDTH'(i % num_tiles), `GLB_WORD_ADDR_WIDTH'(32 + i / 4),
                i % 5 == 4, 1'b1);
        end
        wait_drain();
    endtask

    initial begin
        int unsigned seed_value;
        seed_value = $urandom(32'h4098_5129);
        reset = 1'b1;
        stall = 1'b0;
        host_req = '0;
        tag_seq = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        idle_cycles(settle_cycles);
        run_directed();
        for (int i = 0; i < random_ops; i++) random_op(1'b1, 1'b0);
        wait_drain();
        run_interrupts();
        run_stalls();
        run_reset_midway();
        // quiet tail catches late or extra responses
        idle_cycles(latency + 2);
        if (expect_q.size() != 0) begin
            stop_run($sformatf("%0d reads never answered", expect_q.size()));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* src.f */
+incdir+include
hdl/global_buffer_pkg.sv
hdl/glb_proc_ingress.sv
hdl/glb_tile.sv
hdl/glb_rdrs_egress.sv
hdl/global_buffer.sv
tb/tb_global_buffer.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the global buffer testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_global_buffer \
    -f src.f \
    -o tb_global_buffer

# keep the simulation output for the log search
./obj_dir/tb_global_buffer > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
